// ==== Bender.yml ====
package:
  name: mips_multicycle

sources:
  # Packages first, then RTL bottom-up
  - source/isa_pkg.sv
  - source/ctrl_pkg.sv
  - source/alu.sv
  - source/reg_file.sv
  - source/datapath.sv
  - source/control_fsm.sv
  - source/mips_multicycle.sv

  # Testbench, includes tb_program.svh
  - target: test
    include_dirs:
      - test
    files:
      - test/tb_mips_multicycle.sv

// ==== filelist.f ====
+incdir+test
source/isa_pkg.sv
source/ctrl_pkg.sv
source/alu.sv
source/reg_file.sv
source/datapath.sv
source/control_fsm.sv
source/mips_multicycle.sv
test/tb_mips_multicycle.sv

// ==== source/alu.sv ====
`timescale 1ns/1ps

module alu import isa_pkg::*, ctrl_pkg::*; (
    input  word_t   a,
    input  word_t   b,
    input  alu_op_t op,
    output word_t   y,
    output logic    zero    // Used for branch compare
);

    always_comb begin
        case (op)
            ALU_ADD: y = a + b;
            ALU_SUB: y = a - b;
            ALU_AND: y = a & b;
            ALU_OR:  y = a | b;
            ALU_SLT: y = {31'b0, $signed(a) < $signed(b)};
            ALU_SLL: y = a << b[4:0];   // Shift amount from low bits only
            default: y = '0;
        endcase
    end

    assign zero = (y == '0);

endmodule

// ==== source/control_fsm.sv ====
`timescale 1ns/1ps

module control_fsm import isa_pkg::*, ctrl_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  instr_t     instr,         // Instruction register
    input  logic       alu_zero,
    output logic       pc_en,
    output logic       ir_write,
    output logic       dr_write,
    output logic       reg_write,
    output logic       alu_out_write,
    output logic       mem_write,
    output logic       ior_d,         // 1 selects ALUOut as memory address
    output logic       reg_dst,       // 1 writes rd, 0 writes rt
    output logic       mem_to_reg,    // 1 writes the data register
    output logic       alu_src_a,     // 1 selects A, 0 selects PC
    output logic       ext_sign,
    output logic       use_shamt,
    output alu_op_t    alu_op,
    output src_b_sel_t alu_src_b,
    output pc_src_t    pc_src
);

    state_t     state;
    state_t     state_nxt;
    logic [5:0] opcode;
    logic [5:0] funct;

    assign opcode = instr.r.opcode;
    assign funct  = instr.r.funct;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) state <= S_FETCH;
        else        state <= state_nxt;
    end

    // Next state, dispatch on opcode in decode
    always_comb begin
        state_nxt = S_FETCH;
        case (state)
            S_FETCH:  state_nxt = S_DECODE;
            S_DECODE: begin
                case (opcode)
                    OP_LW, OP_SW:            state_nxt = S_MEM_ADDR;
                    OP_RTYPE:                state_nxt = S_EXEC;
                    OP_ADDI, OP_ANDI, OP_ORI: state_nxt = S_IMM_EXEC;
                    OP_BEQ, OP_BNE:          state_nxt = S_BRANCH;
                    OP_J:                    state_nxt = S_JUMP;
                    default:                 state_nxt = S_FETCH; // Unknown opcode acts as nop
                endcase
            end
            S_MEM_ADDR: state_nxt = (opcode == OP_LW) ? S_MEM_READ : S_MEM_WRITE;
            S_MEM_READ: state_nxt = S_MEM_WB;
            S_EXEC:     state_nxt = S_ALU_WB;
            S_IMM_EXEC: state_nxt = S_IMM_WB;
            default:    state_nxt = S_FETCH; // Every last step returns to fetch
        endcase
    end

    // Control outputs, Moore style except branch pc_en and funct decode
    always_comb begin
        pc_en         = 1'b0;
        ir_write      = 1'b0;
        dr_write      = 1'b0;
        reg_write     = 1'b0;
        alu_out_write = 1'b0;
        mem_write     = 1'b0;
        ior_d         = 1'b0;
        reg_dst       = 1'b0;
        mem_to_reg    = 1'b0;
        alu_src_a     = 1'b0;
        ext_sign      = 1'b0;
        use_shamt     = 1'b0;
        alu_op        = ALU_ADD;
        alu_src_b     = SRCB_REG;
        pc_src        = PCSRC_ALU;
        case (state)
            S_FETCH: begin
                ir_write  = 1'b1;       // Latch instruction at PC
                alu_src_b = SRCB_FOUR;  // PC + 4
                pc_en     = 1'b1;
            end
            S_DECODE: begin
                alu_src_b     = SRCB_BRANCH_OFS; // PC+4 plus offset, ready for a branch
                alu_out_write = 1'b1;
            end
            S_MEM_ADDR: begin
                alu_src_a     = 1'b1;
                alu_src_b     = SRCB_IMM;
                ext_sign      = 1'b1;
                alu_out_write = 1'b1;  // Effective address
            end
            S_MEM_READ: begin
                ior_d    = 1'b1;
                dr_write = 1'b1;
            end
            S_MEM_WB: begin
                reg_write  = 1'b1;
                mem_to_reg = 1'b1;     // Load result to rt
            end
            S_MEM_WRITE: begin
                ior_d     = 1'b1;
                mem_write = 1'b1;
            end
            S_EXEC: begin
                alu_src_a     = 1'b1;
                alu_out_write = 1'b1;
                case (funct)
                    FN_SUB:  alu_op = ALU_SUB;
                    FN_AND:  alu_op = ALU_AND;
                    FN_OR:   alu_op = ALU_OR;
                    FN_SLT:  alu_op = ALU_SLT;
                    FN_SLL: begin
                        alu_op    = ALU_SLL;
                        use_shamt = 1'b1;  // rt shifted by shamt
                    end
                    default: alu_op = ALU_ADD;
                endcase
            end
            S_ALU_WB: begin
                reg_write = 1'b1;
                reg_dst   = 1'b1;
            end
            S_IMM_EXEC: begin
                alu_src_a     = 1'b1;
                alu_src_b     = SRCB_IMM;
                alu_out_write = 1'b1;
                ext_sign      = (opcode == OP_ADDI); // Logical immediates zero-extend
                case (opcode)
                    OP_ANDI: alu_op = ALU_AND;
                    OP_ORI:  alu_op = ALU_OR;
                    default: alu_op = ALU_ADD;
                endcase
            end
            S_IMM_WB: reg_write = 1'b1;
            S_BRANCH: begin
                alu_src_a = 1'b1;
                alu_op    = ALU_SUB;       // Compare rs and rt
                pc_src    = PCSRC_ALUOUT;
                pc_en     = (opcode == OP_BEQ &&  alu_zero) ||
                            (opcode == OP_BNE && !alu_zero);
            end
            S_JUMP: begin
                pc_src = PCSRC_JUMP;
                pc_en  = 1'b1;
            end
            default: ;
        endcase
    end

    // A store strobe only ever follows its address cycle
    a_store_after_addr: assert property (@(posedge clk) disable iff (!rst_n)
        mem_write |-> (state == S_MEM_WRITE) && ($past(state) == S_MEM_ADDR))
        else $error("mem_write outside the store sequence");

    a_state_legal: assert property (@(posedge clk) disable iff (!rst_n)
        state inside {S_FETCH, S_DECODE, S_MEM_ADDR, S_MEM_READ, S_MEM_WB, S_MEM_WRITE,
                      S_EXEC, S_ALU_WB, S_BRANCH, S_IMM_EXEC, S_IMM_WB, S_JUMP})
        else $error("FSM state out of range");

endmodule

// ==== source/ctrl_pkg.sv ====
package ctrl_pkg;

    // Multicycle FSM states
    typedef enum logic [3:0] {
        S_FETCH     = 4'd0,
        S_DECODE    = 4'd1,  // Also precomputes the branch target
        S_MEM_ADDR  = 4'd2,
        S_MEM_READ  = 4'd3,
        S_MEM_WB    = 4'd4,
        S_MEM_WRITE = 4'd5,
        S_EXEC      = 4'd6,  // R-type execute
        S_ALU_WB    = 4'd7,
        S_BRANCH    = 4'd8,
        S_IMM_EXEC  = 4'd9,
        S_IMM_WB    = 4'd10,
        S_JUMP      = 4'd11
    } state_t;

    typedef enum logic [2:0] {
        ALU_ADD = 3'd0,
        ALU_SUB = 3'd1,
        ALU_AND = 3'd2,
        ALU_OR  = 3'd3,
        ALU_SLT = 3'd4,  // Signed
        ALU_SLL = 3'd5
    } alu_op_t;

    // ALU operand B source
    typedef enum logic [1:0] {
        SRCB_REG        = 2'd0, // B register or shamt
        SRCB_FOUR       = 2'd1,
        SRCB_IMM        = 2'd2,
        SRCB_BRANCH_OFS = 2'd3  // Sign-extended immediate times four
    } src_b_sel_t;

    // Next PC source
    typedef enum logic [1:0] {
        PCSRC_ALU    = 2'd0, // PC+4 straight from the ALU
        PCSRC_ALUOUT = 2'd1, // Branch target held in ALUOut
        PCSRC_JUMP   = 2'd2
    } pc_src_t;

endpackage

// ==== source/datapath.sv ====
`timescale 1ns/1ps

module datapath import isa_pkg::*, ctrl_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       pc_en,
    input  logic       ir_write,
    input  logic       dr_write,
    input  logic       reg_write,
    input  logic       alu_out_write,
    input  logic       ior_d,
    input  logic       reg_dst,
    input  logic       mem_to_reg,
    input  logic       alu_src_a,
    input  logic       ext_sign,
    input  logic       use_shamt,
    input  alu_op_t    alu_op,
    input  src_b_sel_t alu_src_b,
    input  pc_src_t    pc_src,
    input  word_t      r_data,
    output word_t      mem_addr,
    output word_t      w_data,
    output instr_t     instr,
    output logic       alu_zero
);

    word_t  pc;
    instr_t ir;
    word_t  dr;       // Load data
    word_t  a_reg;    // rs value
    word_t  b_reg;    // rt value
    word_t  alu_out;

    word_t    rf_rd0;
    word_t    rf_rd1;
    word_t    rf_wd;
    reg_idx_t rf_wa;

    word_t imm_ext;
    word_t branch_ofs;
    word_t jump_addr;
    word_t src_a;
    word_t src_b;
    word_t alu_y;
    word_t pc_nxt;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc      <= START_ADDR;
            ir      <= '0;
            dr      <= '0;
            a_reg   <= '0;
            b_reg   <= '0;
            alu_out <= '0;
        end else begin
            if (pc_en)         pc      <= pc_nxt;
            if (ir_write)      ir      <= r_data;
            if (dr_write)      dr      <= r_data;
            if (alu_out_write) alu_out <= alu_y;
            a_reg <= rf_rd0;  // Operand latches follow the IR fields every cycle
            b_reg <= rf_rd1;
        end
    end

    assign instr    = ir;
    assign mem_addr = ior_d ? alu_out : pc;   // Fetch or data access
    assign w_data   = b_reg;

    // Register file write port
    assign rf_wa = reg_dst ? ir.r.rd : ir.i.rt;
    assign rf_wd = mem_to_reg ? dr : alu_out;

    reg_file u_rf (
        .clk (clk),
        .we  (reg_write),
        .ra0 (ir.r.rs),
        .ra1 (ir.r.rt),
        .wa  (rf_wa),
        .wd  (rf_wd),
        .rd0 (rf_rd0),
        .rd1 (rf_rd1)
    );

    // Immediates
    assign imm_ext    = ext_sign ? {{16{ir.i.imm[15]}}, ir.i.imm} : {16'b0, ir.i.imm};
    assign branch_ofs = {{14{ir.i.imm[15]}}, ir.i.imm, 2'b00};
    assign jump_addr  = {pc[31:28], ir.j.target, 2'b00};  // PC already advanced past the j

    // sll takes rt as the shifted value
    assign src_a = !alu_src_a ? pc :
                   use_shamt  ? b_reg : a_reg;

    always_comb begin
        case (alu_src_b)
            SRCB_REG:        src_b = use_shamt ? {27'b0, ir.r.shamt} : b_reg;
            SRCB_FOUR:       src_b = 32'd4;
            SRCB_IMM:        src_b = imm_ext;
            SRCB_BRANCH_OFS: src_b = branch_ofs;
            default:         src_b = b_reg;
        endcase
    end

    alu u_alu (
        .a    (src_a),
        .b    (src_b),
        .op   (alu_op),
        .y    (alu_y),
        .zero (alu_zero)
    );

    always_comb begin
        case (pc_src)
            PCSRC_ALUOUT: pc_nxt = alu_out;    // Target from decode
            PCSRC_JUMP:   pc_nxt = jump_addr;
            default:      pc_nxt = alu_y;      // Sequential
        endcase
    end

    // Every PC source keeps word alignment
    a_pc_aligned: assert property (@(posedge clk) disable iff (!rst_n)
        pc[1:0] == 2'b00)
        else $error("PC not word aligned: %h", pc);

endmodule

// ==== source/isa_pkg.sv ====
package isa_pkg;

    typedef logic [31:0] word_t;    // Data or address word
    typedef logic [4:0]  reg_idx_t; // Register number

    // R format, register-register ops and shifts
    typedef struct packed {
        logic [5:0] opcode;
        reg_idx_t   rs;
        reg_idx_t   rt;
        reg_idx_t   rd;
        logic [4:0] shamt;
        logic [5:0] funct;
    } r_fmt_t;

    // I format, immediates, loads, stores, branches
    typedef struct packed {
        logic [5:0]  opcode;
        reg_idx_t    rs;
        reg_idx_t    rt;
        logic [15:0] imm;
    } i_fmt_t;

    // J format, word target inside the current 256 MB region
    typedef struct packed {
        logic [5:0]  opcode;
        logic [25:0] target;
    } j_fmt_t;

    // One instruction word seen through each format
    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
        j_fmt_t j;
    } instr_t;

    localparam logic [5:0] OP_RTYPE = 6'h00;
    localparam logic [5:0] OP_J     = 6'h02;
    localparam logic [5:0] OP_BEQ   = 6'h04;
    localparam logic [5:0] OP_BNE   = 6'h05;
    localparam logic [5:0] OP_ADDI  = 6'h08;
    localparam logic [5:0] OP_ANDI  = 6'h0c; // Zero-extended immediate
    localparam logic [5:0] OP_ORI   = 6'h0d; // Zero-extended immediate
    localparam logic [5:0] OP_LW    = 6'h23;
    localparam logic [5:0] OP_SW    = 6'h2b;

    localparam logic [5:0] FN_SLL = 6'h00;
    localparam logic [5:0] FN_ADD = 6'h20;
    localparam logic [5:0] FN_SUB = 6'h22;
    localparam logic [5:0] FN_AND = 6'h24;
    localparam logic [5:0] FN_OR  = 6'h25;
    localparam logic [5:0] FN_SLT = 6'h2a;

    localparam word_t START_ADDR = 32'h0000_0000; // Reset PC

endpackage

// ==== source/mips_multicycle.sv ====
`timescale 1ns/1ps

module mips_multicycle import isa_pkg::*, ctrl_pkg::*; (
    input  logic  clk,
    input  logic  rst_n,
    input  word_t r_data,   // Combinational read data for mem_addr
    output word_t mem_addr,
    output word_t w_data,
    output logic  wr_en     // Store strobe, sampled on the rising edge
);

    // Enables from the FSM
    logic pc_en;
    logic ir_write;
    logic dr_write;
    logic reg_write;
    logic alu_out_write;

    // Mux selects from the FSM
    logic       ior_d;
    logic       reg_dst;
    logic       mem_to_reg;
    logic       alu_src_a;
    logic       ext_sign;
    logic       use_shamt;
    alu_op_t    alu_op;
    src_b_sel_t alu_src_b;
    pc_src_t    pc_src;

    // Status back to the FSM
    instr_t instr;
    logic   alu_zero;

    control_fsm u_ctrl (
        .clk           (clk),
        .rst_n         (rst_n),
        .instr         (instr),
        .alu_zero      (alu_zero),
        .pc_en         (pc_en),
        .ir_write      (ir_write),
        .dr_write      (dr_write),
        .reg_write     (reg_write),
        .alu_out_write (alu_out_write),
        .mem_write     (wr_en),     // Straight out to memory
        .ior_d         (ior_d),
        .reg_dst       (reg_dst),
        .mem_to_reg    (mem_to_reg),
        .alu_src_a     (alu_src_a),
        .ext_sign      (ext_sign),
        .use_shamt     (use_shamt),
        .alu_op        (alu_op),
        .alu_src_b     (alu_src_b),
        .pc_src        (pc_src)
    );

    datapath u_dp (
        .clk           (clk),
        .rst_n         (rst_n),
        .pc_en         (pc_en),
        .ir_write      (ir_write),
        .dr_write      (dr_write),
        .reg_write     (reg_write),
        .alu_out_write (alu_out_write),
        .ior_d         (ior_d),
        .reg_dst       (reg_dst),
        .mem_to_reg    (mem_to_reg),
        .alu_src_a     (alu_src_a),
        .ext_sign      (ext_sign),
        .use_shamt     (use_shamt),
        .alu_op        (alu_op),
        .alu_src_b     (alu_src_b),
        .pc_src        (pc_src),
        .r_data        (r_data),
        .mem_addr      (mem_addr),
        .w_data        (w_data),
        .instr         (instr),
        .alu_zero      (alu_zero)
    );

endmodule

// ==== source/reg_file.sv ====
`timescale 1ns/1ps

module reg_file import isa_pkg::*; (
    input  logic     clk,
    input  logic     we,
    input  reg_idx_t ra0,
    input  reg_idx_t ra1,
    input  reg_idx_t wa,
    input  word_t    wd,
    output word_t    rd0,
    output word_t    rd1
);

    word_t regs [32];

    // Register 0 is never written
    always_ff @(posedge clk) begin
        if (we && wa != '0) regs[wa] <= wd;
    end

    // Combinational reads, zero forced for register 0
    assign rd0 = (ra0 == '0) ? '0 : regs[ra0];
    assign rd1 = (ra1 == '0) ? '0 : regs[ra1];

endmodule

// ==== test/tb_program.svh ====
`ifndef TB_PROGRAM_SVH
`define TB_PROGRAM_SVH

localparam word_t BASE_ADDR   = 32'h0000_0300; // Held in $8, every lw and sw is relative to it
localparam word_t LOAD_ADDR   = 32'h0000_0380; // Preloaded random word
localparam word_t POISON_ADDR = 32'h0000_03f0; // Only skipped stores point here
localparam word_t MARKER_ADDR = 32'h0000_03fc; // Last store of the program

typedef struct {
    word_t addr;
    word_t data;
    string name;
} store_t;

store_t      exp_stores[$];     // Stores in program order
word_t       model [32];        // Register contents by the ISA rules
word_t       emit_pc;
int unsigned lcg_state = 71056;

function automatic word_t lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return {lcg_state[15:0], lcg_state[31:16]}; // Strong high bits end up in the immediates
endfunction

function automatic word_t sext(logic [15:0] v);
    return {{16{v[15]}}, v};
endfunction

function automatic word_t r_instr(logic [5:0] funct, reg_idx_t rd, reg_idx_t rs, reg_idx_t rt,
                                  logic [4:0] shamt);
    instr_t w;
    w.r = '{OP_RTYPE, rs, rt, rd, shamt, funct};
    return w;
endfunction

function automatic word_t i_instr(logic [5:0] op, reg_idx_t rt, reg_idx_t rs, logic [15:0] imm);
    instr_t w;
    w.i = '{op, rs, rt, imm};
    return w;
endfunction

function automatic word_t j_instr(word_t target);
    instr_t w;
    w.j = '{OP_J, target[27:2]};   // Word index inside the region
    return w;
endfunction

function automatic void emit(word_t w);
    mem[emit_pc[9:2]] = w;
    emit_pc += 4;
endfunction

// addi sign-extends, andi and ori zero-extend
function automatic void imm_op(logic [5:0] op, reg_idx_t rt, reg_idx_t rs, logic [15:0] imm);
    emit(i_instr(op, rt, rs, imm));
    case (op)
        OP_ANDI: model[rt] = model[rs] & {16'b0, imm};
        OP_ORI:  model[rt] = model[rs] | {16'b0, imm};
        default: model[rt] = model[rs] + sext(imm);
    endcase
endfunction

function automatic void rtype_op(logic [5:0] funct, reg_idx_t rd, reg_idx_t rs, reg_idx_t rt,
                                 logic [4:0] shamt);
    word_t a;
    word_t b;
    a = model[rs];
    b = model[rt];
    emit(r_instr(funct, rd, rs, rt, shamt));
    case (funct)
        FN_SUB:  model[rd] = a - b;
        FN_AND:  model[rd] = a & b;
        FN_OR:   model[rd] = a | b;
        FN_SLT:  model[rd] = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        FN_SLL:  model[rd] = b << shamt;   // rt shifted by shamt
        default: model[rd] = a + b;
    endcase
endfunction

function automatic void load_op(reg_idx_t rt, logic [15:0] ofs);
    word_t addr;
    addr = model[8] + sext(ofs);
    emit(i_instr(OP_LW, rt, 5'd8, ofs));
    model[rt] = mem[addr[9:2]];
endfunction

// Skipped stores are emitted but never expected
function automatic void store_op(reg_idx_t rt, logic [15:0] ofs, string name, bit expected);
    store_t s;
    emit(i_instr(OP_SW, rt, 5'd8, ofs));
    s.addr = model[8] + sext(ofs);
    s.data = model[rt];
    s.name = name;
    if (expected) begin
        exp_stores.push_back(s);
    end
endfunction

function automatic void build_program();
    word_t r1;
    word_t r2;
    word_t r3;
    word_t r4;
    for (int i = 0; i < 256; i++) begin
        mem[i] = 32'hbad0_0000 | (i << 2);  // Unknown opcode, acts as nop
    end
    model   = '{default: '0};
    emit_pc = START_ADDR;
    mem[LOAD_ADDR[9:2]] = lcg_next();
    r1 = lcg_next() | 32'h8000;   // Negative once sign-extended
    r2 = lcg_next() & 32'h7fff;   // Positive, so never equal to r1
    r3 = lcg_next();
    r4 = lcg_next();

    imm_op(OP_ADDI, 8, 0, BASE_ADDR[15:0]);
    imm_op(OP_ADDI, 1, 0, r1[15:0]);
    imm_op(OP_ADDI, 2, 0, r2[15:0]);
    imm_op(OP_ADDI, 3, 0, r3[15:0]);
    imm_op(OP_ADDI, 4, 0, r4[15:0]);

    // Results go to 0x200 upward through negative offsets
    rtype_op(FN_ADD, 5, 1, 2, 5'd0);
    store_op(5, 16'hff00, "add", 1);
    rtype_op(FN_SUB, 5, 1, 2, 5'd0);
    store_op(5, 16'hff04, "sub", 1);
    rtype_op(FN_AND, 5, 3, 4, 5'd0);
    store_op(5, 16'hff08, "and", 1);
    rtype_op(FN_OR, 5, 3, 4, 5'd0);
    store_op(5, 16'hff0c, "or", 1);
    rtype_op(FN_SLT, 5, 1, 2, 5'd0);
    store_op(5, 16'hff10, "slt_true", 1);
    rtype_op(FN_SLT, 5, 2, 1, 5'd0);
    store_op(5, 16'hff14, "slt_false", 1);
    rtype_op(FN_SLL, 5, 0, 3, r4[4:0] | 5'd1);
    store_op(5, 16'hff18, "sll", 1);

    imm_op(OP_ADDI, 6, 2, r3[15:0] | 16'h8000);
    store_op(6, 16'hff1c, "addi_neg", 1);
    imm_op(OP_ANDI, 6, 1, r4[31:16] | 16'h8000);
    store_op(6, 16'hff20, "andi_zext", 1);
    imm_op(OP_ORI, 6, 2, r3[31:16] | 16'h8000);
    store_op(6, 16'hff24, "ori_zext", 1);

    load_op(7, 16'h0080);
    imm_op(OP_ADDI, 7, 7, 16'h0123);
    store_op(7, 16'hff28, "lw_addi", 1);

    emit(i_instr(OP_BEQ, 1, 1, 16'd1));   // Taken
    store_op(5, 16'h00f0, "beq_skip", 0);
    emit(i_instr(OP_BEQ, 2, 1, 16'd1));   // Falls through
    store_op(1, 16'hff2c, "beq_fall", 1);
    emit(i_instr(OP_BNE, 2, 1, 16'd1));   // Taken
    store_op(5, 16'h00f0, "bne_skip", 0);
    emit(i_instr(OP_BNE, 1, 1, 16'd1));   // Falls through
    store_op(2, 16'hff30, "bne_fall", 1);
    emit(j_instr(emit_pc + 32'd12));      // Over two stores
    store_op(5, 16'h00f0, "j_skip", 0);
    store_op(5, 16'h00f0, "j_skip", 0);

    imm_op(OP_ADDI, 9, 0, 16'h600d);
    store_op(9, 16'h00fc, "marker", 1);
    emit(j_instr(emit_pc));               // Park on itself
endfunction

`endif

// ==== test/tb_mips_multicycle.sv ====
`timescale 1ns/1ps

module tb_mips_multicycle import isa_pkg::*; ();

    localparam int RESET_CYCLES   = 10;
    localparam int PROG_MAX       = 70;  // Instruction slots the program may fill
    localparam int CPI_MAX        = 5;   // lw
    localparam int TIMEOUT_CYCLES = RESET_CYCLES + CPI_MAX * PROG_MAX + 40;

    logic  clk;
    logic  rst_n;
    word_t r_data;
    word_t mem_addr;
    word_t w_data;
    logic  wr_en;

    word_t mem [256];               // Shared instruction and data memory
    int    cycles      = 0;
    int    stores_left = 0;
    logic  store_seen  = 1'b0;      // A store finished on the last edge
    logic  run_done    = 1'b0;
    word_t head_addr;               // Head of the expected list
    word_t head_data;
    string head_name;

    `include "tb_program.svh"

    mips_multicycle dut (
        .clk      (clk),
        .rst_n    (rst_n),
        .r_data   (r_data),
        .mem_addr (mem_addr),
        .w_data   (w_data),
        .wr_en    (wr_en)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    assign r_data = mem[mem_addr[9:2]];   // Same-cycle read

    // Store lands 1 ns after the edge
    always @(posedge clk) begin
        if (rst_n && wr_en) begin
            mem[mem_addr[9:2]] <= #1 w_data;
        end
    end

    always @(posedge clk) begin
        cycles     <= cycles + 1;
        store_seen <= rst_n && wr_en;
    end

    // Head moves half a cycle after each store so it is stable at the checks
    always @(negedge clk) begin
        if (store_seen && stores_left > 0) begin
            void'(exp_stores.pop_front());
            if (exp_stores.size() == 0) begin
                run_done = (head_addr == MARKER_ADDR);
            end
            next_expected();
        end
    end

    function automatic void next_expected();
        stores_left = exp_stores.size();
        if (stores_left > 0) begin
            head_addr = exp_stores[0].addr;
            head_data = exp_stores[0].data;
            head_name = exp_stores[0].name;
        end
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Simulation FAILED");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic report_mismatch(input string test, input word_t expected, input word_t actual);
        abort_run($sformatf("ERROR %s expected %h actual %h", test, expected, actual));
    endtask

    // No store in reset or on the first fetch
    a_reset_quiet: assert property (@(posedge clk) (!rst_n || $rose(rst_n)) |-> !wr_en)
        else report_mismatch("reset_wr_en", 32'd0, {31'b0, $sampled(wr_en)});

    a_reset_pc: assert property (@(posedge clk) $rose(rst_n) |-> mem_addr == START_ADDR)
        else report_mismatch("reset_pc", START_ADDR, $sampled(mem_addr));

    a_store_addr: assert property (@(posedge clk) disable iff (!rst_n)
        wr_en |-> mem_addr == head_addr)
        else report_mismatch({head_name, "_addr"}, head_addr, $sampled(mem_addr));

    a_store_data: assert property (@(posedge clk) disable iff (!rst_n)
        wr_en |-> w_data == head_data)
        else report_mismatch({head_name, "_data"}, head_data, $sampled(w_data));

    // Skipped branch and jump paths must never store
    a_no_poison: assert property (@(posedge clk) disable iff (!rst_n)
        wr_en |-> mem_addr != POISON_ADDR)
        else abort_run("A store on a skipped path reached the poison address");

    initial begin
        rst_n = 1'b0;
        build_program();
        next_expected();
        repeat (RESET_CYCLES) @(posedge clk);
        #1 rst_n = 1'b1;
        do begin
            @(negedge clk);
        end while (!run_done && cycles < TIMEOUT_CYCLES);
        if (run_done) begin
            $display("Simulation PASSED");
            $finish;
        end else begin
            abort_run($sformatf("Timeout after %0d cycles with %0d stores still expected",
                                cycles, stores_left));
        end
    end

endmodule
